// ==== verilog/ex_pkg.sv ====
package ex_pkg;

    localparam int XLEN       = 32;  // data and address width
    localparam int REG_ADDR_W = 5;   // gpr index
    localparam int VSEG_W     = 3;   // dmw segment field

    // alu operation, one per arithmetic/logic form
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_NOR  = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10,
        ALU_LUI  = 4'd11   // lu12i, imm already shifted by decode
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NONE  = 4'd0,
        MEM_LD_W  = 4'd1,
        MEM_LD_B  = 4'd2,
        MEM_LD_BU = 4'd3,
        MEM_LD_H  = 4'd4,
        MEM_LD_HU = 4'd5,
        MEM_ST_W  = 4'd6,
        MEM_ST_B  = 4'd7,
        MEM_ST_H  = 4'd8
    } mem_op_e;

    // same code as the sram size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } mem_size_e;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rj_value;
        logic [XLEN-1:0]       rkd_value;   // rk or rd, store data too
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] dest;
        logic                  gr_we;
        alu_op_e               alu_op;
        logic                  src1_is_pc;
        logic                  src2_is_imm;
        mem_op_e               mem_op;
    } ex_issue_t;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic                  gr_we;       // already cleared on exception
        logic [REG_ADDR_W-1:0] dest;
        logic [XLEN-1:0]       result;
        mem_op_e               mem_op;
        logic [1:0]            addr_low;    // byte lane for load extract
        logic                  ex_ale;
        logic                  ex_xlate_miss;
    } ex_result_t;

    typedef struct packed {
        logic                  valid;
        logic                  gr_we;
        logic [REG_ADDR_W-1:0] dest;
        logic                  is_load;     // decode must stall, no bypass
        logic [XLEN-1:0]       result;
    } ex_forward_t;

    typedef struct packed {
        logic              plv0;
        logic              plv3;
        logic [1:0]        mat;
        logic [VSEG_W-1:0] pseg;
        logic [VSEG_W-1:0] vseg;
    } dmw_cfg_t;

    typedef struct packed {
        logic       crmd_da;
        logic       crmd_pg;
        logic [1:0] plv;
        logic [1:0] datm;
    } xlate_ctrl_t;

    typedef struct packed {
        logic            wr;
        mem_size_e       size;
        logic [3:0]      wstrb;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } data_req_t;

    function automatic logic is_load_op(input mem_op_e op);
        return (op == MEM_LD_W) || (op == MEM_LD_B) || (op == MEM_LD_BU) ||
               (op == MEM_LD_H) || (op == MEM_LD_HU);
    endfunction

    function automatic logic is_store_op(input mem_op_e op);
        return (op == MEM_ST_W) || (op == MEM_ST_B) || (op == MEM_ST_H);
    endfunction

endpackage

// ==== verilog/ex_alu.sv ====
`timescale 1ns/10ps

module ex_alu
    import ex_pkg::*;
(
    input  ex_issue_t       issue,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [4:0]      shamt;     // shift amount, low five bits only

    // operand select
    assign src1  = issue.src1_is_pc  ? issue.pc  : issue.rj_value;   // pcaddu12i, jirl link
    assign src2  = issue.src2_is_imm ? issue.imm : issue.rkd_value;
    assign shamt = src2[4:0];

    always_comb
    begin
        case (issue.alu_op)
            ALU_ADD:
            begin
                result = src1 + src2;   // also load/store address
            end
            ALU_SUB:
            begin
                result = src1 - src2;
            end
            ALU_SLT:
            begin
                result = {{(XLEN-1){1'b0}}, $signed(src1) < $signed(src2)};
            end
            ALU_SLTU:
            begin
                result = {{(XLEN-1){1'b0}}, src1 < src2};
            end
            ALU_AND:
            begin
                result = src1 & src2;
            end
            ALU_OR:
            begin
                result = src1 | src2;
            end
            ALU_NOR:
            begin
                result = ~(src1 | src2);
            end
            ALU_XOR:
            begin
                result = src1 ^ src2;
            end
            ALU_SLL:
            begin
                result = src1 << shamt;
            end
            ALU_SRL:
            begin
                result = src1 >> shamt;
            end
            ALU_SRA:
            begin
                result = $unsigned($signed(src1) >>> shamt);   // sign fill
            end
            ALU_LUI:
            begin
                result = src2;   // imm carries the upper 20 bits
            end
            default:
            begin
                result = '0;     // unused encodings
            end
        endcase
    end

endmodule

// ==== verilog/ex_addr_translate.sv ====
`timescale 1ns/10ps

module ex_addr_translate
    import ex_pkg::*;
(
    input  logic [XLEN-1:0] vaddr,
    input  xlate_ctrl_t     xlate,
    input  dmw_cfg_t        dmw0,
    input  dmw_cfg_t        dmw1,
    output logic [XLEN-1:0] paddr,
    output logic            xlate_miss
);

    logic direct_mode;   // da=1 pg=0
    logic mapped_mode;   // da=0 pg=1
    logic hit0;
    logic hit1;

    // window match: plv enable, memory type, top segment
    function automatic logic window_hit(input dmw_cfg_t win, input xlate_ctrl_t ctl,
                                        input logic [VSEG_W-1:0] seg);
        logic plv_ok;
        plv_ok = ((ctl.plv == 2'd0) && win.plv0) || ((ctl.plv == 2'd3) && win.plv3);
        return plv_ok && (win.mat == ctl.datm) && (seg == win.vseg);
    endfunction

    assign direct_mode = xlate.crmd_da & ~xlate.crmd_pg;
    assign mapped_mode = ~xlate.crmd_da & xlate.crmd_pg;

    assign hit0 = window_hit(dmw0, xlate, vaddr[XLEN-1 -: VSEG_W]);
    assign hit1 = window_hit(dmw1, xlate, vaddr[XLEN-1 -: VSEG_W]);

    always_comb
    begin
        paddr      = '0;
        xlate_miss = 1'b0;
        if (direct_mode)
        begin
            paddr = vaddr;
        end
        else if (mapped_mode)
        begin
            if (hit0)   // dmw0 wins on overlap
            begin
                paddr = {dmw0.pseg, vaddr[XLEN-VSEG_W-1:0]};
            end
            else if (hit1)
            begin
                paddr = {dmw1.pseg, vaddr[XLEN-VSEG_W-1:0]};
            end
            else
            begin
                xlate_miss = 1'b1;   // stands in for tlb refill
            end
        end
    end

endmodule

// ==== verilog/ex_mem_request.sv ====
`timescale 1ns/10ps

module ex_mem_request
    import ex_pkg::*;
(
    input  mem_op_e         mem_op,
    input  logic [XLEN-1:0] paddr,
    input  logic [XLEN-1:0] store_data,
    output mem_size_e       size,
    output logic [3:0]      wstrb,
    output logic [XLEN-1:0] wdata,
    output logic            ale
);

    logic [1:0] offset;   // byte within word
    logic       is_word;
    logic       is_half;

    assign offset = paddr[1:0];

    assign is_word = (mem_op == MEM_LD_W) || (mem_op == MEM_ST_W);
    assign is_half = (mem_op == MEM_LD_H) || (mem_op == MEM_LD_HU) || (mem_op == MEM_ST_H);

    // byte accesses are never misaligned
    assign ale = (is_word && (offset != 2'b00)) || (is_half && offset[0]);

    always_comb
    begin
        if (is_word)
        begin
            size = SIZE_WORD;
        end
        else if (is_half)
        begin
            size = SIZE_HALF;
        end
        else
        begin
            size = SIZE_BYTE;   // b forms, also the idle value
        end
    end

    always_comb
    begin
        wstrb = 4'b0000;   // loads write nothing
        wdata = '0;
        case (mem_op)
            MEM_ST_W:
            begin
                wstrb = 4'b1111;
                wdata = store_data;
            end
            MEM_ST_B:
            begin
                wstrb = 4'b0001 << offset;        // one lane
                wdata = {4{store_data[7:0]}};     // byte on every lane
            end
            MEM_ST_H:
            begin
                wstrb = offset[1] ? 4'b1100 : 4'b0011;
                wdata = {2{store_data[15:0]}};
            end
            default:
            begin
                wstrb = 4'b0000;
                wdata = '0;
            end
        endcase
    end

endmodule

// ==== verilog/ex_stage.sv ====
`timescale 1ns/10ps

module ex_stage
    import ex_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        flush,          // ertn or wb exception
    input  logic        ms_ex,

    input  logic        ds_to_es_valid,
    output logic        es_allow_in,
    input  ex_issue_t   ds_to_es_bus,

    output logic        es_to_ms_valid,
    input  logic        ms_allow_in,
    output ex_result_t  es_to_ms_bus,

    output ex_forward_t es_to_ds_bus,

    output logic        data_req,
    output data_req_t   data_req_bus,
    input  logic        data_addr_ok,

    input  xlate_ctrl_t xlate,
    input  dmw_cfg_t    dmw0,
    input  dmw_cfg_t    dmw1
);

    ex_issue_t       es_issue;       // stage register, payload only
    logic            es_valid;
    logic            es_ready_go;

    logic [XLEN-1:0] alu_result;     // also the virtual address
    logic [XLEN-1:0] paddr;
    logic            xlate_miss;
    logic            mem_ale;
    mem_size_e       mem_size;
    logic [3:0]      mem_wstrb;
    logic [XLEN-1:0] mem_wdata;

    logic            es_is_load;
    logic            es_is_store;
    logic            es_is_mem;
    logic            es_ale;
    logic            es_xlate_miss;
    logic            es_ex;          // any exception held in ex

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            es_valid <= 1'b0;
        end
        else if (flush)
        begin
            es_valid <= 1'b0;   // drop whatever is held
        end
        else if (es_allow_in)
        begin
            es_valid <= ds_to_es_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (ds_to_es_valid && es_allow_in)
        begin
            es_issue <= ds_to_es_bus;
        end
    end

    ex_alu u_alu (
        .issue  (es_issue),
        .result (alu_result)
    );

    ex_addr_translate u_xlate (
        .vaddr      (alu_result),
        .xlate      (xlate),
        .dmw0       (dmw0),
        .dmw1       (dmw1),
        .paddr      (paddr),
        .xlate_miss (xlate_miss)
    );

    ex_mem_request u_mem_req (
        .mem_op     (es_issue.mem_op),
        .paddr      (paddr),
        .store_data (es_issue.rkd_value),
        .size       (mem_size),
        .wstrb      (mem_wstrb),
        .wdata      (mem_wdata),
        .ale        (mem_ale)
    );

    assign es_is_load  = is_load_op(es_issue.mem_op);
    assign es_is_store = is_store_op(es_issue.mem_op);
    assign es_is_mem   = es_is_load | es_is_store;

    // translation only matters for load/store
    assign es_ale        = es_valid & mem_ale;
    assign es_xlate_miss = es_valid & es_is_mem & xlate_miss;
    assign es_ex         = es_ale | es_xlate_miss;

    // no request behind a stalled or excepting ms, nor on a faulting access
    assign data_req = es_valid & es_is_mem & ms_allow_in & ~ms_ex & ~es_ex & ~flush;

    assign es_ready_go = es_ex     ? 1'b1 :                      // report at once
                         es_is_mem ? (data_req & data_addr_ok) :  // address accepted
                                     1'b1;

    assign es_allow_in    = ~es_valid | (es_ready_go & ms_allow_in);
    assign es_to_ms_valid = es_valid & es_ready_go;

    always_comb
    begin
        data_req_bus.wr    = es_is_store;
        data_req_bus.size  = mem_size;
        data_req_bus.wstrb = mem_wstrb;
        data_req_bus.addr  = paddr;
        data_req_bus.wdata = mem_wdata;
    end

    always_comb
    begin
        es_to_ms_bus.pc            = es_issue.pc;
        es_to_ms_bus.gr_we         = es_issue.gr_we & ~es_ex;   // no write-back on fault
        es_to_ms_bus.dest          = es_issue.dest;
        es_to_ms_bus.result        = alu_result;
        es_to_ms_bus.mem_op        = es_issue.mem_op;
        es_to_ms_bus.addr_low      = paddr[1:0];
        es_to_ms_bus.ex_ale        = es_ale;
        es_to_ms_bus.ex_xlate_miss = es_xlate_miss;
    end

    // bypass record, is_load makes decode wait
    always_comb
    begin
        es_to_ds_bus.valid   = es_valid;
        es_to_ds_bus.gr_we   = es_issue.gr_we;
        es_to_ds_bus.dest    = es_issue.dest;
        es_to_ds_bus.is_load = es_is_load;
        es_to_ds_bus.result  = alu_result;
    end

endmodule

// ==== test/ex_stage_properties.sv ====
`timescale 1ns/10ps

module ex_stage_properties
    import ex_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      flush,
    input logic      ds_to_es_valid,
    input logic      es_allow_in,
    input logic      es_valid,
    input logic      es_to_ms_valid,
    input logic      ms_allow_in,
    input logic      data_req,
    input data_req_t data_req_bus,
    input logic      es_xlate_miss
);

    logic held;             // occupancy rebuilt from the two handshakes
    logic req_misaligned;   // alignment as seen on the request bus

    always_ff @(posedge clk)
    begin
        if (reset || flush)
        begin
            held <= 1'b0;
        end
        else if (ds_to_es_valid && es_allow_in)
        begin
            held <= 1'b1;   // enter wins over a same-edge leave
        end
        else if (es_to_ms_valid && ms_allow_in)
        begin
            held <= 1'b0;
        end
    end

    assign req_misaligned =
        ((data_req_bus.size == SIZE_WORD) && (data_req_bus.addr[1:0] != 2'b00)) ||
        ((data_req_bus.size == SIZE_HALF) && data_req_bus.addr[0]);

    // request only from a held instruction
    a_req_needs_valid: assert property (@(posedge clk) disable iff (reset)
        data_req |-> held)
        else $error("data_req without a held instruction");

    // faulting access never goes to memory
    a_req_no_fault: assert property (@(posedge clk) disable iff (reset)
        data_req |-> (!req_misaligned && !es_xlate_miss))
        else $error("data_req with misaligned address or translation miss");

    a_out_needs_valid: assert property (@(posedge clk) disable iff (reset)
        es_to_ms_valid |-> held)
        else $error("es_to_ms_valid without a held instruction");

    a_flush_clears: assert property (@(posedge clk) disable iff (reset)
        flush |=> (!es_valid && !data_req && !es_to_ms_valid))
        else $error("stage still active after flush");

endmodule

bind ex_stage ex_stage_properties u_props (
    .clk            (clk),
    .reset          (reset),
    .flush          (flush),
    .ds_to_es_valid (ds_to_es_valid),
    .es_allow_in    (es_allow_in),
    .es_valid       (es_valid),
    .es_to_ms_valid (es_to_ms_valid),
    .ms_allow_in    (ms_allow_in),
    .data_req       (data_req),
    .data_req_bus   (data_req_bus),
    .es_xlate_miss  (es_xlate_miss)
);

// ==== test/ex_stage_tb.sv ====
`timescale 1ns/10ps

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int TIMEOUT = 50;   // cycles per wait loop

    logic        clk;
    logic        reset;
    logic        flush;
    logic        ms_ex;
    logic        ds_to_es_valid;
    logic        es_allow_in;
    ex_issue_t   ds_to_es_bus;
    logic        es_to_ms_valid;
    logic        ms_allow_in;
    ex_result_t  es_to_ms_bus;
    ex_forward_t es_to_ds_bus;
    logic        data_req;
    data_req_t   data_req_bus;
    logic        data_addr_ok;
    xlate_ctrl_t xlate;
    dmw_cfg_t    dmw0;
    dmw_cfg_t    dmw1;

    integer      seed;
    int          errors;
    int          checks;
    logic        mem_stall;     // holds addr_ok low
    logic [1:0]  ok_delay;
    logic [31:0] mem_rnd;

    ex_stage DUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // delay for the next request, picked while the accept is pending
    always @(negedge clk)
    begin
        if (data_req && data_addr_ok)
        begin
            mem_rnd = $random(seed);
        end
    end

    // data memory, accepts the address 0..3 cycles after the request
    always @(posedge clk)
    begin
        if (reset || mem_stall)
        begin
            data_addr_ok <= 1'b0;
        end
        else if (data_req && data_addr_ok)
        begin
            data_addr_ok <= 1'b0;
            ok_delay <= mem_rnd[1:0];
        end
        else if (data_req)
        begin
            if (ok_delay == 2'd0)
                data_addr_ok <= 1'b1;
            else
                ok_delay <= ok_delay - 2'd1;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_fail(input string what);
        errors++;
        $display("failure at %0t: %s", $time, what);
    endtask

    // reference models from the stage rules
    function automatic logic [31:0] alu_model(input ex_issue_t i);
        logic [31:0] a;
        logic [31:0] b;
        a = i.src1_is_pc ? i.pc : i.rj_value;
        b = i.src2_is_imm ? i.imm : i.rkd_value;
        case (i.alu_op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            ALU_SLTU: return (a < b) ? 32'd1 : 32'd0;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_NOR:  return ~a & ~b;
            ALU_XOR:  return (a | b) & ~(a & b);
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            ALU_LUI:  return b;
            default:  return 32'd0;
        endcase
    endfunction

    function automatic logic load_kind(input mem_op_e op);
        case (op)
            MEM_LD_W, MEM_LD_B, MEM_LD_BU, MEM_LD_H, MEM_LD_HU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic mem_size_e size_model(input mem_op_e op);
        case (op)
            MEM_LD_W, MEM_ST_W:            return SIZE_WORD;
            MEM_LD_H, MEM_LD_HU, MEM_ST_H: return SIZE_HALF;
            default:                       return SIZE_BYTE;
        endcase
    endfunction

    function automatic logic [3:0] strb_model(input mem_op_e op, input logic [1:0] off);
        logic [3:0] s;
        s = 4'b0000;
        if (op == MEM_ST_W)
            s = 4'b1111;
        else if (op == MEM_ST_B)
            s[off] = 1'b1;
        else if (op == MEM_ST_H)
            s = off[1] ? 4'b1100 : 4'b0011;
        return s;
    endfunction

    function automatic logic [31:0] wdata_model(input mem_op_e op, input logic [31:0] d);
        if (op == MEM_ST_W)
            return d;
        else if (op == MEM_ST_B)
            return {d[7:0], d[7:0], d[7:0], d[7:0]};
        else if (op == MEM_ST_H)
            return {d[15:0], d[15:0]};
        return 32'd0;
    endfunction

    // {miss, paddr} for the current mode
    function automatic logic [32:0] xlate_model(input logic [31:0] va, input xlate_ctrl_t c,
                                                input dmw_cfg_t w0, input dmw_cfg_t w1);
        dmw_cfg_t win [2];
        logic     priv;
        win[0] = w0;
        win[1] = w1;
        if (c.crmd_da && !c.crmd_pg)
            return {1'b0, va};       // direct, no translation
        if (c.crmd_da || !c.crmd_pg)
            return {1'b0, 32'd0};    // neither direct nor mapped
        for (int n = 0; n < 2; n++)
        begin
            priv = (c.plv == 2'd0) ? win[n].plv0 : ((c.plv == 2'd3) ? win[n].plv3 : 1'b0);
            if (priv && win[n].mat == c.datm && va[31:29] == win[n].vseg)
                return {1'b0, win[n].pseg, va[28:0]};   // first hit wins
        end
        return {1'b1, 32'd0};
    endfunction

    function automatic ex_issue_t mem_issue(input logic [31:0] base, input logic [31:0] off,
                                            input logic [31:0] data, input mem_op_e op);
        ex_issue_t i;
        i.pc          = 32'h1c00_0000 + off;
        i.rj_value    = base;
        i.rkd_value   = data;
        i.imm         = off;
        i.dest        = 5'd7;
        i.gr_we       = load_kind(op);
        i.alu_op      = ALU_ADD;
        i.src1_is_pc  = 1'b0;
        i.src2_is_imm = 1'b1;
        i.mem_op      = op;
        return i;
    endfunction

    task automatic send(input ex_issue_t issue);
        int   wait_cnt;
        logic taken;
        wait_cnt = 0;
        taken = 1'b0;
        @(posedge clk);
        ds_to_es_valid <= 1'b1;
        ds_to_es_bus   <= issue;
        while (!taken && wait_cnt < TIMEOUT)
        begin
            @(negedge clk);
            if (es_allow_in)
                taken = 1'b1;
            else
                wait_cnt++;
        end
        @(posedge clk);
        ds_to_es_valid <= 1'b0;
        if (!taken)
            report_fail("decode handshake never accepted the instruction");
    endtask

    task automatic check_forward(input ex_issue_t issue);
        check_val("fwd.valid", 32'(es_to_ds_bus.valid), 32'd1);
        check_val("fwd.gr_we", 32'(es_to_ds_bus.gr_we), 32'(issue.gr_we));
        check_val("fwd.dest", 32'(es_to_ds_bus.dest), 32'(issue.dest));
        check_val("fwd.is_load", 32'(es_to_ds_bus.is_load), 32'(load_kind(issue.mem_op)));
        check_val("fwd.result", es_to_ds_bus.result, alu_model(issue));
    endtask

    // waits for the memory-side transfer, notes any request on the way
    task automatic collect(input ex_issue_t issue, output ex_result_t res,
                           output logic req_seen, output data_req_t req);
        int   wait_cnt;
        logic done;
        wait_cnt = 0;
        done = 1'b0;
        req_seen = 1'b0;
        res = '0;
        req = '0;
        while (!done && wait_cnt < TIMEOUT)
        begin
            @(negedge clk);
            if (wait_cnt == 0)
                check_forward(issue);
            if (data_req)
            begin
                req_seen = 1'b1;
                req = data_req_bus;
            end
            if (es_to_ms_valid && ms_allow_in)
            begin
                done = 1'b1;
                res = es_to_ms_bus;
            end
            wait_cnt++;
        end
        if (done)
            @(posedge clk);
        else
            report_fail("instruction never reached the memory stage");
    endtask

    task automatic test_alu();
        ex_issue_t   iss;
        ex_result_t  res;
        logic        seen;
        data_req_t   req;
        logic [31:0] rnd;
        for (int k = 0; k < 12; k++)
        begin
            repeat (3)
            begin
                iss.pc        = $random(seed);
                iss.rj_value  = $random(seed);
                iss.rkd_value = $random(seed);
                iss.imm       = $random(seed);
                rnd           = $random(seed);
                iss.dest        = rnd[4:0];
                iss.gr_we       = rnd[5];
                iss.src1_is_pc  = rnd[6];
                iss.src2_is_imm = rnd[7];
                iss.alu_op      = alu_op_e'(4'(k));
                iss.mem_op      = MEM_NONE;
                send(iss);
                collect(iss, res, seen, req);
                check_val("result", res.result, alu_model(iss));
                check_val("gr_we", 32'(res.gr_we), 32'(iss.gr_we));
                check_val("dest", 32'(res.dest), 32'(iss.dest));
                check_val("data_req", 32'(seen), 32'd0);
            end
        end
    endtask

    task automatic store_case(input mem_op_e op, input logic [1:0] off);
        ex_issue_t   iss;
        ex_result_t  res;
        logic        seen;
        data_req_t   req;
        logic [31:0] base;
        base = $random(seed);
        base[1:0] = 2'b00;
        iss = mem_issue(base, 32'(off), $random(seed), op);
        send(iss);
        collect(iss, res, seen, req);
        check_val("data_req", 32'(seen), 32'd1);
        check_val("req.wr", 32'(req.wr), (op >= MEM_ST_W) ? 32'd1 : 32'd0);
        check_val("req.size", 32'(req.size), 32'(size_model(op)));
        check_val("req.wstrb", 32'(req.wstrb), 32'(strb_model(op, off)));
        check_val("req.wdata", req.wdata, wdata_model(op, iss.rkd_value));
        check_val("req.addr", req.addr, base + 32'(off));
        check_val("ex_ale", 32'(res.ex_ale), 32'd0);
        check_val("mem_op", 32'(res.mem_op), 32'(op));
        check_val("addr_low", 32'(res.addr_low), 32'(off));   // base is word aligned
    endtask

    task automatic test_store_encoding();
        store_case(MEM_ST_W, 2'd0);
        store_case(MEM_ST_H, 2'd0);
        store_case(MEM_ST_H, 2'd2);
        for (int o = 0; o < 4; o++)
        begin
            store_case(MEM_ST_B, 2'(o));
            store_case(MEM_LD_B, 2'(o));
            store_case(MEM_LD_BU, 2'(o));
        end
        store_case(MEM_LD_W, 2'd0);
        store_case(MEM_LD_H, 2'd2);
        store_case(MEM_LD_HU, 2'd0);
    endtask

    task automatic misalign_case(input mem_op_e op, input logic [1:0] off, input logic bad);
        ex_issue_t  iss;
        ex_result_t res;
        logic       seen;
        data_req_t  req;
        iss = mem_issue(32'h0000_4000, 32'(off), $random(seed), op);
        iss.gr_we = 1'b1;
        send(iss);
        collect(iss, res, seen, req);
        check_val("data_req", 32'(seen), 32'(!bad));
        check_val("ex_ale", 32'(res.ex_ale), 32'(bad));
        check_val("gr_we", 32'(res.gr_we), 32'(!bad));
        check_val("mem_op", 32'(res.mem_op), 32'(op));
        check_val("addr_low", 32'(res.addr_low), 32'(off));
    endtask

    task automatic test_misalign();
        for (int o = 1; o < 4; o++)
        begin
            misalign_case(MEM_ST_W, 2'(o), 1'b1);
            misalign_case(MEM_LD_W, 2'(o), 1'b1);
            misalign_case(MEM_ST_B, 2'(o), 1'b0);
        end
        misalign_case(MEM_LD_H, 2'd1, 1'b1);
        misalign_case(MEM_LD_HU, 2'd3, 1'b1);
        misalign_case(MEM_ST_H, 2'd3, 1'b1);
        misalign_case(MEM_LD_BU, 2'd3, 1'b0);
    endtask

    task automatic trans_case(input xlate_ctrl_t c, input dmw_cfg_t w0, input dmw_cfg_t w1,
                              input logic [31:0] va);
        ex_issue_t   iss;
        ex_result_t  res;
        logic        seen;
        data_req_t   req;
        logic [32:0] exp;
        @(posedge clk);
        xlate <= c;
        dmw0  <= w0;
        dmw1  <= w1;
        exp = xlate_model(va, c, w0, w1);
        iss = mem_issue(va, 32'd0, $random(seed), MEM_LD_W);
        send(iss);
        collect(iss, res, seen, req);
        check_val("ex_xlate_miss", 32'(res.ex_xlate_miss), 32'(exp[32]));
        check_val("data_req", 32'(seen), 32'(!exp[32]));
        check_val("gr_we", 32'(res.gr_we), 32'(!exp[32]));
        if (!exp[32])
            check_val("req.addr", req.addr, exp[31:0]);
    endtask

    task automatic test_translation();
        xlate_ctrl_t mapped;
        dmw_cfg_t    w0;
        dmw_cfg_t    w1;
        mapped = '{crmd_da: 1'b0, crmd_pg: 1'b1, plv: 2'd0, datm: 2'd1};
        w0 = '{plv0: 1'b1, plv3: 1'b0, mat: 2'd1, pseg: 3'b000, vseg: 3'b101};
        w1 = '{plv0: 1'b1, plv3: 1'b1, mat: 2'd1, pseg: 3'b010, vseg: 3'b100};
        trans_case(mapped, w0, w1, 32'ha012_3450);   // window 0
        trans_case(mapped, w0, w1, 32'h8abc_def0);   // window 1
        w1.vseg = 3'b101;
        trans_case(mapped, w0, w1, 32'hb000_0100);   // both hit
        w0.plv3 = 1'b0;
        w1.plv3 = 1'b0;
        mapped.plv = 2'd3;
        trans_case(mapped, w0, w1, 32'ha000_0040);   // privilege mismatch
        mapped.plv = 2'd0;
        mapped.datm = 2'd0;
        trans_case(mapped, w0, w1, 32'ha000_0080);   // mat mismatch
        trans_case('{1'b1, 1'b0, 2'd0, 2'd0}, w0, w1, 32'h0000_2000);
    endtask

    task automatic test_backpressure_flush();
        ex_issue_t  iss;
        ex_result_t res;
        logic       seen;
        data_req_t  req;
        int         wait_cnt;
        @(posedge clk);
        ms_allow_in <= 1'b0;
        iss = mem_issue(32'h0000_8000, 32'd4, $random(seed), MEM_ST_W);
        send(iss);
        repeat (6)
        begin
            @(negedge clk);
            check_val("data_req", 32'(data_req), 32'd0);
            check_val("es_to_ms_valid", 32'(es_to_ms_valid), 32'd0);
            check_val("es_allow_in", 32'(es_allow_in), 32'd0);
        end
        @(posedge clk);
        ms_allow_in <= 1'b1;
        collect(iss, res, seen, req);
        check_val("result", res.result, 32'h0000_8004);
        check_val("pc", res.pc, iss.pc);
        check_val("data_req", 32'(seen), 32'd1);
        // ms exception holds the request back
        @(posedge clk);
        ms_ex <= 1'b1;
        iss = mem_issue(32'h0000_8800, 32'd8, $random(seed), MEM_ST_B);
        send(iss);
        repeat (4)
        begin
            @(negedge clk);
            check_val("data_req", 32'(data_req), 32'd0);
            check_val("es_to_ms_valid", 32'(es_to_ms_valid), 32'd0);
            check_val("es_allow_in", 32'(es_allow_in), 32'd0);
        end
        @(posedge clk);
        ms_ex <= 1'b0;
        collect(iss, res, seen, req);
        check_val("data_req", 32'(seen), 32'd1);
        check_val("req.addr", req.addr, 32'h0000_8808);
        // flush while the address is still pending
        @(posedge clk);
        mem_stall <= 1'b1;
        iss = mem_issue(32'h0000_9000, 32'd0, 32'd0, MEM_LD_W);
        send(iss);
        wait_cnt = 0;
        @(negedge clk);
        while (!data_req && wait_cnt < TIMEOUT)
        begin
            @(negedge clk);
            wait_cnt++;
        end
        if (!data_req)
            report_fail("load never raised data_req before the flush");
        @(posedge clk);
        flush <= 1'b1;
        @(posedge clk);
        flush     <= 1'b0;
        mem_stall <= 1'b0;   // memory would accept a leftover request now
        repeat (6)
        begin
            @(negedge clk);
            check_val("data_req", 32'(data_req), 32'd0);
            check_val("es_to_ms_valid", 32'(es_to_ms_valid), 32'd0);
            check_val("fwd.valid", 32'(es_to_ds_bus.valid), 32'd0);
        end
    endtask

    initial
    begin
        seed           = 32'h33bb_c4a7;
        errors         = 0;
        checks         = 0;
        reset          = 1'b1;
        flush          = 1'b0;
        ms_ex          = 1'b0;
        ds_to_es_valid = 1'b0;
        ds_to_es_bus   = '0;
        ms_allow_in    = 1'b1;
        xlate          = '{crmd_da: 1'b1, crmd_pg: 1'b0, plv: 2'd0, datm: 2'd0};
        dmw0           = '0;
        dmw1           = '0;
        mem_stall      = 1'b0;
        ok_delay       = 2'd0;
        data_addr_ok   = 1'b0;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_alu();
        test_store_encoding();
        test_misalign();
        test_translation();
        test_backpressure_flush();
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== ex_stage.f ====
verilog/ex_pkg.sv
verilog/ex_alu.sv
verilog/ex_addr_translate.sv
verilog/ex_mem_request.sv
verilog/ex_stage.sv
test/ex_stage_properties.sv
test/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert -f ex_stage.f --top-module ex_stage_tb -o ex_stage_sim

# the simulation may exit nonzero on an assertion, the grep below decides
sim_output=$(./obj_dir/ex_stage_sim 2>&1) || true
echo "$sim_output"

if echo "$sim_output" | grep -q "^>>> PASS$"; then
    exit 0
else
    echo "simulation did not report a pass"
    exit 1
fi
